// File: src/rvx_defs.svh
/* Address map and sizing macros for the RVX system bus.
   Include wherever a region, the RAM size or the bank count is needed. */
`ifndef RVX_DEFS_SVH
`define RVX_DEFS_SVH

// RAM size in bytes, must be a power of two
`define RVX_MEMORY_SIZE 1024

// Region base addresses
`define RVX_RAM_BASE 32'h0000_0000
`define RVX_MTIMER_BASE 32'h8001_0000
`define RVX_GPIO_BASE 32'h8002_0000

// Timer region covers mtime and mtimecmp
`define RVX_MTIMER_SIZE 32

// GPIO banks sit back to back from the GPIO base
`define RVX_GPIO_STRIDE 16
`define RVX_NUM_GPIO_BANKS 4

// RAM, timer, then one slot per GPIO bank
`define RVX_NUM_DEVICES (2 + `RVX_NUM_GPIO_BANKS)

`endif

// File: src/rvx_pkg.sv
/* Shared bus types and device indices for the RVX subsystem.
   Compile before every RTL file that refers to rvx_pkg. */
`include "rvx_defs.svh"

package rvx_pkg;

  // Bus address and data word
  typedef logic [31:0] word_t;

  // One write enable per byte lane
  typedef logic [3:0] strobe_t;

  // Register offset inside a peripheral
  typedef logic [4:0] reg_offset_t;

  // One bit per device on the bus
  typedef logic [`RVX_NUM_DEVICES-1:0] device_mask_t;

  // Pins of a single GPIO bank
  typedef logic [7:0] gpio_byte_t;

  // Device slots on the bus, banks follow the timer
  localparam int DEV_RAM = 0;
  localparam int DEV_MTIMER = 1;
  localparam int DEV_GPIO0 = 2;

endpackage

// File: src/rvx_bus_decoder.sv
/* Routes manager request pulses to the device whose region holds the address.
   Addresses are rebased per device; unmapped accesses are acknowledged here. */
`timescale 1ns/1ps
`include "rvx_defs.svh"

module rvx_bus_decoder (
  input  logic                  clock,
  input  logic                  arst_n,
  input  rvx_pkg::word_t        rw_address,
  input  rvx_pkg::word_t        write_data,
  input  rvx_pkg::strobe_t      write_strobe,
  input  logic                  read_request,
  input  logic                  write_request,
  output rvx_pkg::word_t        device_rw_address,
  output rvx_pkg::word_t        device_write_data,
  output rvx_pkg::strobe_t      device_write_strobe,
  output rvx_pkg::device_mask_t device_read_request,
  output rvx_pkg::device_mask_t device_write_request,
  // Bit 0 answers a read, bit 1 a write
  output logic [1:0]            unmapped_response
);
  import rvx_pkg::*;

  localparam word_t GPIO_SPAN = `RVX_GPIO_STRIDE * `RVX_NUM_GPIO_BANKS;

  word_t        ram_offset;
  word_t        mtimer_offset;
  word_t        gpio_offset;
  word_t        gpio_index;
  device_mask_t device_select;

  // Offsets wrap below the base, so one compare checks both bounds
  assign ram_offset    = rw_address - `RVX_RAM_BASE;
  assign mtimer_offset = rw_address - `RVX_MTIMER_BASE;
  assign gpio_offset   = rw_address - `RVX_GPIO_BASE;
  assign gpio_index    = gpio_offset / `RVX_GPIO_STRIDE;

  always_comb begin
    device_select     = '0;
    device_rw_address = rw_address;
    if (ram_offset < `RVX_MEMORY_SIZE) begin
      device_select[DEV_RAM] = 1'b1;
      device_rw_address      = ram_offset;
    end else if (mtimer_offset < `RVX_MTIMER_SIZE) begin
      device_select[DEV_MTIMER] = 1'b1;
      device_rw_address         = mtimer_offset;
    end else if (gpio_offset < GPIO_SPAN) begin
      device_select[DEV_GPIO0 + gpio_index] = 1'b1;
      device_rw_address = gpio_offset - gpio_index * `RVX_GPIO_STRIDE;
    end
  end

  assign device_read_request  = read_request ? device_select : '0;
  assign device_write_request = write_request ? device_select : '0;
  assign device_write_data    = write_data;
  assign device_write_strobe  = write_strobe;

  // Same one-cycle latency as a real device
  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      unmapped_response <= '0;
    end else begin
      unmapped_response <= {write_request, read_request} & {2{device_select == '0}};
    end
  end

  // Manager never issues both kinds of request together
  assert property (@(posedge clock) disable iff (!arst_n)
    !(read_request && write_request));

  // A request reaches at most one device and never both request lines
  assert property (@(posedge clock) disable iff (!arst_n)
    $onehot0({device_read_request, device_write_request}));

endmodule

// File: src/rvx_bus_response_mux.sv
/* Merges device responses back onto the manager port.
   Read data comes from the one device that answers; unmapped reads return zero. */
`timescale 1ns/1ps
`include "rvx_defs.svh"

module rvx_bus_response_mux (
  input  rvx_pkg::word_t [`RVX_NUM_DEVICES-1:0] device_read_data,
  input  rvx_pkg::device_mask_t                 device_read_response,
  input  rvx_pkg::device_mask_t                 device_write_response,
  input  logic [1:0]                            unmapped_response,
  output rvx_pkg::word_t                        read_data,
  output logic                                  read_response,
  output logic                                  write_response
);
  import rvx_pkg::*;

  // Only the answering slice gets through
  always_comb begin
    read_data = '0;
    for (int i = 0; i < `RVX_NUM_DEVICES; i++) begin
      if (device_read_response[i]) begin
        read_data = read_data | device_read_data[i];
      end
    end
  end

  assign read_response  = (|device_read_response) | unmapped_response[0];
  assign write_response = (|device_write_response) | unmapped_response[1];

  // One transfer in flight, so devices and decoder never answer together
  always_comb begin
    assert final ($onehot0({device_read_response, device_write_response,
                            unmapped_response}));
  end

endmodule

// File: src/rvx_ram.sv
/* Word-organised RAM on the system bus with byte-strobed writes.
   Reads and both response pulses arrive one cycle after the request. */
`timescale 1ns/1ps
`include "rvx_defs.svh"

module rvx_ram (
  input  logic             clock,
  input  logic             arst_n,
  input  rvx_pkg::word_t   rw_address,
  input  rvx_pkg::word_t   write_data,
  input  rvx_pkg::strobe_t write_strobe,
  input  logic             read_request,
  input  logic             write_request,
  output rvx_pkg::word_t   read_data,
  output logic             read_response,
  output logic             write_response
);
  import rvx_pkg::*;

  localparam int NUM_WORDS = `RVX_MEMORY_SIZE / 4;
  localparam int INDEX_W = $clog2(NUM_WORDS);

  word_t              mem [NUM_WORDS];
  logic [INDEX_W-1:0] word_index;

  // Byte offset bits are dropped
  assign word_index = rw_address[INDEX_W+1:2];

  always_ff @(posedge clock) begin
    if (write_request) begin
      for (int lane = 0; lane < 4; lane++) begin
        if (write_strobe[lane]) begin
          mem[word_index][8*lane +: 8] <= write_data[8*lane +: 8];
        end
      end
    end
    if (read_request) begin
      read_data <= mem[word_index];
    end
  end

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      read_response  <= 1'b0;
      write_response <= 1'b0;
    end else begin
      read_response  <= read_request;
      write_response <= write_request;
    end
  end

  // Decoder must hand over an offset that fits the array
  assert property (@(posedge clock) disable iff (!arst_n)
    (read_request || write_request) |-> (rw_address < `RVX_MEMORY_SIZE));

endmodule

// File: src/rvx_mtimer.sv
/* RISC-V machine timer: free-running 64-bit mtime and a 64-bit mtimecmp.
   Raises irq while mtime has reached mtimecmp; both halves are bus writable. */
`timescale 1ns/1ps

module rvx_mtimer (
  input  logic                 clock,
  input  logic                 arst_n,
  input  rvx_pkg::reg_offset_t rw_address,
  input  rvx_pkg::word_t       write_data,
  input  rvx_pkg::strobe_t     write_strobe,
  input  logic                 read_request,
  input  logic                 write_request,
  output rvx_pkg::word_t       read_data,
  output logic                 read_response,
  output logic                 write_response,
  output logic                 irq
);
  import rvx_pkg::*;

  localparam reg_offset_t MTIME_LO = 5'd0;
  localparam reg_offset_t MTIME_HI = 5'd4;
  localparam reg_offset_t MTIMECMP_LO = 5'd8;
  localparam reg_offset_t MTIMECMP_HI = 5'd12;

  logic [63:0] mtime;
  logic [63:0] mtimecmp;
  logic [63:0] mtime_next;
  logic [63:0] mtimecmp_next;

  function automatic word_t merge_lanes(word_t old_word, word_t new_word, strobe_t strobe);
    word_t merged;
    merged = old_word;
    for (int lane = 0; lane < 4; lane++) begin
      if (strobe[lane]) begin
        merged[8*lane +: 8] = new_word[8*lane +: 8];
      end
    end
    return merged;
  endfunction

  // A bus write wins over the increment for the half it hits
  always_comb begin
    mtime_next    = mtime + 64'd1;
    mtimecmp_next = mtimecmp;
    if (write_request) begin
      case (rw_address)
        MTIME_LO:    mtime_next[31:0] = merge_lanes(mtime[31:0], write_data, write_strobe);
        MTIME_HI:    mtime_next[63:32] = merge_lanes(mtime[63:32], write_data, write_strobe);
        MTIMECMP_LO: mtimecmp_next[31:0] = merge_lanes(mtimecmp[31:0], write_data,
                                                       write_strobe);
        MTIMECMP_HI: mtimecmp_next[63:32] = merge_lanes(mtimecmp[63:32], write_data,
                                                        write_strobe);
        default:     mtimecmp_next = mtimecmp;
      endcase
    end
  end

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      mtime          <= '0;
      mtimecmp       <= '1;
      irq            <= 1'b0;
      read_response  <= 1'b0;
      write_response <= 1'b0;
    end else begin
      mtime          <= mtime_next;
      mtimecmp       <= mtimecmp_next;
      irq            <= (mtime >= mtimecmp);
      read_response  <= read_request;
      write_response <= write_request;
    end
  end

  always_ff @(posedge clock) begin
    if (read_request) begin
      case (rw_address)
        MTIME_LO:    read_data <= mtime[31:0];
        MTIME_HI:    read_data <= mtime[63:32];
        MTIMECMP_LO: read_data <= mtimecmp[31:0];
        MTIMECMP_HI: read_data <= mtimecmp[63:32];
        default:     read_data <= '0;
      endcase
    end
  end

  // Compare starts at all ones, so no spurious interrupt after reset
  assert property (@(posedge clock) $rose(arst_n) |=> !irq);

endmodule

// File: src/rvx_gpio_bank.sv
/* One 8-pin GPIO bank: synchronised inputs, output and output-enable registers.
   Replicated per bank at the top level, each bank with its own bus slot. */
`timescale 1ns/1ps

module rvx_gpio_bank (
  input  logic                 clock,
  input  logic                 arst_n,
  input  rvx_pkg::reg_offset_t rw_address,
  input  rvx_pkg::word_t       write_data,
  input  rvx_pkg::strobe_t     write_strobe,
  input  logic                 read_request,
  input  logic                 write_request,
  input  rvx_pkg::gpio_byte_t  gpio_input,
  output rvx_pkg::word_t       read_data,
  output logic                 read_response,
  output logic                 write_response,
  output rvx_pkg::gpio_byte_t  gpio_output,
  output rvx_pkg::gpio_byte_t  gpio_oe
);
  import rvx_pkg::*;

  localparam reg_offset_t INPUT_REG = 5'd0;
  localparam reg_offset_t OUTPUT_REG = 5'd4;
  localparam reg_offset_t OE_REG = 5'd8;

  gpio_byte_t input_meta;
  gpio_byte_t input_sync;

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      input_meta     <= '0;
      input_sync     <= '0;
      gpio_output    <= '0;
      gpio_oe        <= '0;
      read_response  <= 1'b0;
      write_response <= 1'b0;
    end else begin
      // Two-flop synchroniser on the pins
      input_meta     <= gpio_input;
      input_sync     <= input_meta;
      read_response  <= read_request;
      write_response <= write_request;
      if (write_request && write_strobe[0]) begin
        if (rw_address == OUTPUT_REG) begin
          gpio_output <= write_data[7:0];
        end
        if (rw_address == OE_REG) begin
          gpio_oe <= write_data[7:0];
        end
      end
    end
  end

  // Input register is read-only, writes there just get acknowledged
  always_ff @(posedge clock) begin
    if (read_request) begin
      case (rw_address)
        INPUT_REG:  read_data <= {24'b0, input_sync};
        OUTPUT_REG: read_data <= {24'b0, gpio_output};
        OE_REG:     read_data <= {24'b0, gpio_oe};
        default:    read_data <= '0;
      endcase
    end
  end

endmodule

// File: src/rvx_subsystem.sv
/* System-bus side of the RVX microcontroller, driven from its manager port.
   Connects decoder, RAM, timer, the GPIO bank row and the response collector. */
`timescale 1ns/1ps
`include "rvx_defs.svh"

module rvx_subsystem (
  input  logic                                          clock,
  input  logic                                          arst_n,
  input  rvx_pkg::word_t                                rw_address,
  input  rvx_pkg::word_t                                write_data,
  input  rvx_pkg::strobe_t                              write_strobe,
  input  logic                                          read_request,
  input  logic                                          write_request,
  input  rvx_pkg::gpio_byte_t [`RVX_NUM_GPIO_BANKS-1:0] gpio_input,
  output rvx_pkg::word_t                                read_data,
  output logic                                          read_response,
  output logic                                          write_response,
  output logic                                          timer_irq,
  output rvx_pkg::gpio_byte_t [`RVX_NUM_GPIO_BANKS-1:0] gpio_output,
  output rvx_pkg::gpio_byte_t [`RVX_NUM_GPIO_BANKS-1:0] gpio_oe
);
  import rvx_pkg::*;

  // Shared device side of the bus
  word_t                         device_rw_address;
  word_t                         device_write_data;
  strobe_t                       device_write_strobe;
  device_mask_t                  device_read_request;
  device_mask_t                  device_write_request;
  device_mask_t                  device_read_response;
  device_mask_t                  device_write_response;
  word_t [`RVX_NUM_DEVICES-1:0]  device_read_data;
  logic [1:0]                    unmapped_response;

  rvx_bus_decoder rvx_bus_decoder_instance (
    .clock               (clock),
    .arst_n              (arst_n),
    .rw_address          (rw_address),
    .write_data          (write_data),
    .write_strobe        (write_strobe),
    .read_request        (read_request),
    .write_request       (write_request),
    .device_rw_address   (device_rw_address),
    .device_write_data   (device_write_data),
    .device_write_strobe (device_write_strobe),
    .device_read_request (device_read_request),
    .device_write_request(device_write_request),
    .unmapped_response   (unmapped_response)
  );

  rvx_ram rvx_ram_instance (
    .clock         (clock),
    .arst_n        (arst_n),
    .rw_address    (device_rw_address),
    .write_data    (device_write_data),
    .write_strobe  (device_write_strobe),
    .read_request  (device_read_request[DEV_RAM]),
    .write_request (device_write_request[DEV_RAM]),
    .read_data     (device_read_data[DEV_RAM]),
    .read_response (device_read_response[DEV_RAM]),
    .write_response(device_write_response[DEV_RAM])
  );

  rvx_mtimer rvx_mtimer_instance (
    .clock         (clock),
    .arst_n        (arst_n),
    .rw_address    (device_rw_address[4:0]),
    .write_data    (device_write_data),
    .write_strobe  (device_write_strobe),
    .read_request  (device_read_request[DEV_MTIMER]),
    .write_request (device_write_request[DEV_MTIMER]),
    .read_data     (device_read_data[DEV_MTIMER]),
    .read_response (device_read_response[DEV_MTIMER]),
    .write_response(device_write_response[DEV_MTIMER]),
    .irq           (timer_irq)
  );

  // Bank i owns device slot DEV_GPIO0 + i and byte i of the pin buses
  for (genvar i = 0; i < `RVX_NUM_GPIO_BANKS; i++) begin : g_gpio_bank
    rvx_gpio_bank rvx_gpio_bank_instance (
      .clock         (clock),
      .arst_n        (arst_n),
      .rw_address    (device_rw_address[4:0]),
      .write_data    (device_write_data),
      .write_strobe  (device_write_strobe),
      .read_request  (device_read_request[DEV_GPIO0 + i]),
      .write_request (device_write_request[DEV_GPIO0 + i]),
      .gpio_input    (gpio_input[i]),
      .read_data     (device_read_data[DEV_GPIO0 + i]),
      .read_response (device_read_response[DEV_GPIO0 + i]),
      .write_response(device_write_response[DEV_GPIO0 + i]),
      .gpio_output   (gpio_output[i]),
      .gpio_oe       (gpio_oe[i])
    );
  end

  rvx_bus_response_mux rvx_bus_response_mux_instance (
    .device_read_data     (device_read_data),
    .device_read_response (device_read_response),
    .device_write_response(device_write_response),
    .unmapped_response    (unmapped_response),
    .read_data            (read_data),
    .read_response        (read_response),
    .write_response       (write_response)
  );

endmodule

// File: test/tb_clock_gen.sv
/* Testbench clock and reset source.
   Free-running clock, arst_n held low for a few cycles then released. */
`timescale 1ns/1ps

module tb_clock_gen #(
  parameter int PERIOD_NS = 10,
  parameter int RESET_CYCLES = 2
) (
  output logic clock,
  output logic arst_n
);

  initial begin
    clock = 1'b0;
    forever #(PERIOD_NS / 2) clock = ~clock;
  end

  // Release just after an edge, like all other stimulus
  initial begin
    arst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clock);
    #1;
    arst_n = 1'b1;
  end

endmodule

// File: test/tb_checker.sv
/* Watches the manager port, timer interrupt and GPIO pins of the subsystem.
   Compares them with expected values and prints one line per finished test. */
`timescale 1ns/1ps
`include "rvx_defs.svh"

module tb_checker (
  input  logic                                          clock,
  input  logic                                          arst_n,
  input  rvx_pkg::word_t                                rw_address,
  input  rvx_pkg::word_t                                write_data,
  input  rvx_pkg::strobe_t                              write_strobe,
  input  logic                                          read_request,
  input  logic                                          write_request,
  input  rvx_pkg::word_t                                read_data,
  input  logic                                          read_response,
  input  logic                                          write_response,
  input  logic                                          timer_irq,
  input  rvx_pkg::gpio_byte_t [`RVX_NUM_GPIO_BANKS-1:0] gpio_output,
  input  rvx_pkg::gpio_byte_t [`RVX_NUM_GPIO_BANKS-1:0] gpio_oe,
  input  logic [1:0]                                    expect_kind,
  input  rvx_pkg::word_t                                expect_word,
  input  logic                                          irq_check,
  input  logic                                          irq_expected,
  input  logic                                          test_done,
  input  logic [7:0]                                    test_id,
  output int                                            error_count,
  output int                                            check_count
);
  import rvx_pkg::*;

  // How a read result is judged
  localparam logic [1:0] AT_LEAST = 2'd1;
  localparam logic [1:0] ABOVE_LAST = 2'd2;

  logic       pending_read;
  logic       pending_write;
  word_t      req_address;
  word_t      req_data;
  word_t      req_expect;
  strobe_t    req_strobe;
  logic [1:0] req_kind;
  word_t      last_read;
  gpio_byte_t model_output [`RVX_NUM_GPIO_BANKS];
  gpio_byte_t model_oe [`RVX_NUM_GPIO_BANKS];
  int         test_checks;
  int         test_errors;

  function automatic string name_of_test(logic [7:0] id);
    case (id)
      8'h01:   return "reset state";
      8'h02:   return "ram access";
      8'h03:   return "unmapped access";
      8'h04:   return "gpio outputs";
      8'h05:   return "gpio inputs";
      8'h06:   return "timer counter";
      8'h07:   return "timer interrupt";
      default: return "unnamed";
    endcase
  endfunction

  function automatic logic read_matches(logic [1:0] kind, word_t value, word_t expected,
                                        word_t previous);
    if ($isunknown(value)) begin
      return 1'b0;
    end
    case (kind)
      AT_LEAST:   return value >= expected;
      ABOVE_LAST: return value > previous;
      default:    return value == expected;
    endcase
  endfunction

  task automatic report_mismatch(string message);
    $display("CHECK FAILED at %0t ns: %s", $time, message);
    error_count++;
    test_errors++;
  endtask

  task automatic count_check();
    check_count++;
    test_checks++;
  endtask

  // Expected pin state follows every write that lands in a GPIO bank
  task automatic apply_gpio_write();
    word_t offset;
    int    bank;
    offset = req_address - `RVX_GPIO_BASE;
    if (offset < `RVX_GPIO_STRIDE * `RVX_NUM_GPIO_BANKS && req_strobe[0]) begin
      bank = int'(offset / `RVX_GPIO_STRIDE);
      if (offset % `RVX_GPIO_STRIDE == 4) begin
        model_output[bank] = req_data[7:0];
      end
      if (offset % `RVX_GPIO_STRIDE == 8) begin
        model_oe[bank] = req_data[7:0];
      end
    end
  endtask

  task automatic compare_gpio();
    for (int b = 0; b < `RVX_NUM_GPIO_BANKS; b++) begin
      count_check();
      if (gpio_output[b] !== model_output[b]) begin
        report_mismatch($sformatf("gpio_output of bank %0d is %h, expected %h",
                                  b, gpio_output[b], model_output[b]));
      end
      if (gpio_oe[b] !== model_oe[b]) begin
        report_mismatch($sformatf("gpio_oe of bank %0d is %h, expected %h",
                                  b, gpio_oe[b], model_oe[b]));
      end
    end
  endtask

  initial begin
    error_count   = 0;
    check_count   = 0;
    test_checks   = 0;
    test_errors   = 0;
    pending_read  = 1'b0;
    pending_write = 1'b0;
    last_read     = '0;
    for (int b = 0; b < `RVX_NUM_GPIO_BANKS; b++) begin
      model_output[b] = '0;
      model_oe[b]     = '0;
    end
  end

  // Falling edge sampling, between the DUT edge and the next stimulus change
  always @(negedge clock) begin
    if (!arst_n) begin
      pending_read  = 1'b0;
      pending_write = 1'b0;
    end else begin
      // A request seen last cycle must be answered in this one, and only then
      if (pending_read || pending_write) begin
        count_check();
      end
      if (read_response !== pending_read) begin
        report_mismatch($sformatf("read_response is %b, expected %b",
                                  read_response, pending_read));
      end
      if (write_response !== pending_write) begin
        report_mismatch($sformatf("write_response is %b, expected %b",
                                  write_response, pending_write));
      end
      if (pending_read && read_response === 1'b1) begin
        count_check();
        if (!read_matches(req_kind, read_data, req_expect, last_read)) begin
          report_mismatch($sformatf("read of %h returned %h, expected %h (mode %0d)",
                                    req_address, read_data, req_expect, req_kind));
        end
        last_read = read_data;
      end
      if (pending_write && write_response === 1'b1) begin
        apply_gpio_write();
        compare_gpio();
      end
      if (irq_check) begin
        count_check();
        if (timer_irq !== irq_expected) begin
          report_mismatch($sformatf("timer_irq is %b, expected %b", timer_irq, irq_expected));
        end
      end
      pending_read  = read_request;
      pending_write = write_request;
      req_address   = rw_address;
      req_data      = write_data;
      req_strobe    = write_strobe;
      req_kind      = expect_kind;
      req_expect    = expect_word;
      if (test_done) begin
        $display("Test %-16s %0d checks, %0d errors", name_of_test(test_id),
                 test_checks, test_errors);
        test_checks = 0;
        test_errors = 0;
      end
    end
  end

endmodule

// File: test/tb_rvx.sv
/* Testbench top for the RVX bus subsystem.
   Replays the operations of the stimulus file on the manager port and GPIO pins. */
`timescale 1ns/1ps
`include "rvx_defs.svh"

module tb_rvx;
  import rvx_pkg::*;

  localparam int FIELDS = 6;
  localparam int MAX_OPS = 128;
  localparam int RESPONSE_LIMIT = 16;

  logic                                 clock;
  logic                                 arst_n;
  word_t                                rw_address;
  word_t                                write_data;
  strobe_t                              write_strobe;
  logic                                 read_request;
  logic                                 write_request;
  gpio_byte_t [`RVX_NUM_GPIO_BANKS-1:0] gpio_input;
  word_t                                read_data;
  logic                                 read_response;
  logic                                 write_response;
  logic                                 timer_irq;
  gpio_byte_t [`RVX_NUM_GPIO_BANKS-1:0] gpio_output;
  gpio_byte_t [`RVX_NUM_GPIO_BANKS-1:0] gpio_oe;
  logic [1:0]                           expect_kind;
  word_t                                expect_word;
  logic                                 irq_check;
  logic                                 irq_expected;
  logic                                 test_done;
  logic [7:0]                           test_id;
  int                                   error_count;
  int                                   check_count;
  int                                   driver_errors;
  int                                   op_count;
  word_t                                records [FIELDS*MAX_OPS];

  tb_clock_gen #(.PERIOD_NS(10), .RESET_CYCLES(2)) clock_gen (
    .clock (clock),
    .arst_n(arst_n)
  );

  rvx_subsystem dut (
    .clock         (clock),
    .arst_n        (arst_n),
    .rw_address    (rw_address),
    .write_data    (write_data),
    .write_strobe  (write_strobe),
    .read_request  (read_request),
    .write_request (write_request),
    .gpio_input    (gpio_input),
    .read_data     (read_data),
    .read_response (read_response),
    .write_response(write_response),
    .timer_irq     (timer_irq),
    .gpio_output   (gpio_output),
    .gpio_oe       (gpio_oe)
  );

  tb_checker bus_checker (
    .clock         (clock),
    .arst_n        (arst_n),
    .rw_address    (rw_address),
    .write_data    (write_data),
    .write_strobe  (write_strobe),
    .read_request  (read_request),
    .write_request (write_request),
    .read_data     (read_data),
    .read_response (read_response),
    .write_response(write_response),
    .timer_irq     (timer_irq),
    .gpio_output   (gpio_output),
    .gpio_oe       (gpio_oe),
    .expect_kind   (expect_kind),
    .expect_word   (expect_word),
    .irq_check     (irq_check),
    .irq_expected  (irq_expected),
    .test_done     (test_done),
    .test_id       (test_id),
    .error_count   (error_count),
    .check_count   (check_count)
  );

  // Inputs change 1 ns after the rising edge
  task automatic next_cycle();
    @(posedge clock);
    #1;
  endtask

  task automatic bus_access(input logic is_write, input word_t address, input word_t data,
                            input strobe_t strobe, input logic [1:0] kind,
                            input word_t expected);
    int waited;
    rw_address    = address;
    write_data    = data;
    write_strobe  = strobe;
    expect_kind   = kind;
    expect_word   = expected;
    read_request  = !is_write;
    write_request = is_write;
    next_cycle();
    read_request  = 1'b0;
    write_request = 1'b0;
    waited = 0;
    while (!(read_response || write_response) && waited < RESPONSE_LIMIT) begin
      next_cycle();
      waited++;
    end
    if (waited == RESPONSE_LIMIT) begin
      $display("No response from the DUT for address %h after %0d cycles", address, waited);
      driver_errors++;
    end
    next_cycle();
  endtask

  // Give the interrupt up to limit cycles to reach the level and have it checked
  task automatic wait_for_irq(input logic level, input int limit);
    int waited;
    waited = 0;
    while (timer_irq !== level && waited < limit) begin
      next_cycle();
      waited++;
    end
    irq_expected = level;
    irq_check    = 1'b1;
    next_cycle();
    irq_check    = 1'b0;
  endtask

  initial begin
    word_t op;
    word_t test;
    word_t address;
    word_t data;
    word_t strobe_word;
    word_t expected;
    int    count;
    rw_address    = '0;
    write_data    = '0;
    write_strobe  = '0;
    read_request  = 1'b0;
    write_request = 1'b0;
    gpio_input    = '0;
    expect_kind   = 2'd0;
    expect_word   = '0;
    irq_check     = 1'b0;
    irq_expected  = 1'b0;
    test_done     = 1'b0;
    test_id       = '0;
    driver_errors = 0;
    op_count      = 0;
    for (int i = 0; i < FIELDS * MAX_OPS; i++) begin
      records[i] = '0;
    end
    $readmemh("test/bus_input.txt", records);
    count = 0;
    while (count < MAX_OPS && records[count * FIELDS] != 0) begin
      count++;
    end
    op_count = count;
    if (count == 0) begin
      $display("No operations found in the stimulus file");
      driver_errors++;
    end
    wait (arst_n === 1'b1);
    next_cycle();
    for (int n = 0; n < count; n++) begin
      op          = records[n * FIELDS];
      test        = records[n * FIELDS + 1];
      address     = records[n * FIELDS + 2];
      data        = records[n * FIELDS + 3];
      strobe_word = records[n * FIELDS + 4];
      expected    = records[n * FIELDS + 5];
      test_id     = test[7:0];
      case (op)
        32'd1: bus_access(1'b1, address, data, strobe_word[3:0], 2'd0, expected);
        32'd2: bus_access(1'b0, address, data, strobe_word[3:0], 2'd0, expected);
        32'd3: begin
          gpio_input = data;
          next_cycle();
        end
        32'd4: wait_for_irq(expected[0], int'(data));
        32'd5: repeat (data) next_cycle();
        32'd6: bus_access(1'b0, address, data, strobe_word[3:0], 2'd1, expected);
        32'd7: bus_access(1'b0, address, data, strobe_word[3:0], 2'd2, expected);
        default: begin
          $display("Unknown operation %0h in record %0d of the stimulus file", op, n);
          driver_errors++;
        end
      endcase
      if (n == count - 1 || records[(n + 1) * FIELDS + 1] != test) begin
        test_done = 1'b1;
        next_cycle();
        test_done = 1'b0;
      end
    end
    next_cycle();
    $display("Checks: %0d, errors: %0d, driver errors: %0d",
             check_count, error_count, driver_errors);
    if (error_count == 0 && driver_errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

  // Budget of 50 cycles per operation plus slack for reset and idle gaps
  initial begin
    wait (op_count > 0);
    repeat (op_count * 50 + 2000) @(posedge clock);
    $display("Timeout: the operation sequence did not complete in time");
    $display("Finished with errors");
    $finish;
  end

endmodule

// File: test/bus_input.txt
// op test address data strobe expected, all hex
// op: 1 write, 2 read, 3 set pins, 4 wait irq, 5 idle, 6 read at least, 7 read above last
4 1 00000000 00000005 0 00000000
1 2 00000000 11223344 f 00000000
1 2 00000004 55667788 f 00000000
1 2 000003fc deadbeef f 00000000
2 2 00000000 00000000 0 11223344
2 2 00000004 00000000 0 55667788
2 2 000003fc 00000000 0 deadbeef
1 2 00000004 0000aa00 2 00000000
2 2 00000004 00000000 0 5566aa88
1 2 00000000 99000000 8 00000000
2 2 00000000 00000000 0 99223344
2 3 40000000 00000000 0 00000000
1 3 40000000 12345678 f 00000000
2 3 80010020 00000000 0 00000000
2 3 80020040 00000000 0 00000000
1 4 80020004 000000a5 1 00000000
1 4 80020008 0000000f 1 00000000
1 4 80020014 0000005a 1 00000000
1 4 80020028 000000f0 1 00000000
1 4 80020034 000000c3 1 00000000
1 4 80020038 0000003c 1 00000000
2 4 80020004 00000000 0 000000a5
2 4 80020008 00000000 0 0000000f
2 4 80020014 00000000 0 0000005a
2 4 80020018 00000000 0 00000000
2 4 80020028 00000000 0 000000f0
2 4 80020034 00000000 0 000000c3
2 4 80020038 00000000 0 0000003c
3 5 00000000 c3a55a3c 0 00000000
5 5 00000000 00000005 0 00000000
2 5 80020000 00000000 0 0000003c
2 5 80020010 00000000 0 0000005a
2 5 80020020 00000000 0 000000a5
2 5 80020030 00000000 0 000000c3
1 6 80010004 00000000 f 00000000
1 6 80010000 00001000 f 00000000
6 6 80010000 00000000 0 00001000
5 6 00000000 0000000a 0 00000000
7 6 80010000 00000000 0 00000000
1 7 80010000 00000000 f 00000000
1 7 8001000c 00000000 f 00000000
1 7 80010008 00000020 f 00000000
4 7 00000000 00000064 0 00000001
1 7 8001000c ffffffff f 00000000
4 7 00000000 00000064 0 00000000

// File: sources.f
+incdir+src
src/rvx_pkg.sv
src/rvx_bus_decoder.sv
src/rvx_bus_response_mux.sv
src/rvx_ram.sv
src/rvx_mtimer.sv
src/rvx_gpio_bank.sv
src/rvx_subsystem.sv
test/tb_clock_gen.sv
test/tb_checker.sv
test/tb_rvx.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build the testbench with Verilator, run it and judge the log.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -f sources.f --top-module tb_rvx \
  -Mdir build -o tb_rvx_sim

./build/tb_rvx_sim > sim.log 2>&1
cat sim.log

if grep -qx "Finished with no errors" sim.log; then
  echo "Simulation passed"
else
  echo "Simulation failed"
  exit 1
fi
